//--- bench/glue_checker.sv
/* reference models for port mapping, option pulses, rom words
   and load status, plus the comparing process */
`default_nettype none

module glue_checker #(
	parameter int dl_first = 'h7300,
	parameter int dl_last  = 'h7500
) (
	input  wire logic                     clk_sys,
	input  wire logic                     arst_n,
	input  wire logic [3:0]               test_id,
	input  wire logic                     end_chk,
	input  wire defender_pkg::core_mod_t  core_mod,
	input  wire defender_pkg::status_t    status,
	input  wire defender_pkg::controls_t  controls,
	input  wire logic                     dl_download,
	input  wire logic                     dl_valid,
	input  wire logic                     dl_credit,
	input  wire logic                     main_wr,
	input  wire defender_pkg::mem_word_t  main_word,
	input  wire logic                     main_credit,
	input  wire logic                     snd_wr,
	input  wire defender_pkg::mem_word_t  snd_word,
	input  wire logic                     snd_credit,
	input  wire defender_pkg::port_byte_t input0,
	input  wire defender_pkg::port_byte_t input1,
	input  wire defender_pkg::port_byte_t input2,
	input  wire logic                     mayday,
	input  wire logic [1:0]               orientation,
	input  wire logic                     rom_loaded,
	input  wire logic                     core_reset,
	input  wire logic                     led,
	output int                            err_map,
	output int                            err_wr,
	output int                            err_flow,
	output int                            err_load
);

	typedef struct packed {
		defender_pkg::port_byte_t in0;
		defender_pkg::port_byte_t in1;
		defender_pkg::port_byte_t in2;
		logic                     mayday;
		logic [1:0]               orient;
	} map_t;

	localparam int main_exp = (defender_pkg::SND_BASE - dl_first) / 2;
	localparam int snd_exp  = (dl_last - defender_pkg::SND_BASE + 2) / 2;

	int   main_n, snd_n, main_out, snd_out, src_cr;
	int   adv_left, hsr_left;
	logic adv_prev, hsr_prev, exp_cr;
	map_t exp_map, act_map;

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1: return "mapping";
			4'd2: return "pulse";
			4'd3: return "download";
			default: return "idle";
		endcase
	endfunction

	function automatic logic [7:0] img(input int a);
		return a[7:0] ^ 8'h5A;
	endfunction

	// expected port bytes for one variant
	function automatic map_t map_ref(input defender_pkg::core_mod_t g,
		input defender_pkg::status_t s, input defender_pkg::controls_t c,
		input logic adv, input logic hsr);
		map_t r;
		r = '0;
		r.orient = 2'b10;
		case (g)
			7'd0: begin
				r.in0[0] = s[7];
				r.in0[1] = adv;
				r.in0[3] = hsr;
				r.in0[4] = c.coin1;
				r.in1 = {c.down, c.left | c.right, c.one_player, c.two_players,
					c.fire_d, c.fire_c, c.fire_b, c.fire_a};
				r.in2[0] = c.up;
			end
			7'd1: begin
				r.orient = 2'b01;
				r.in0[0] = s[10];
				r.in0[1] = s[11];
				r.in0[4] = c.coin1;
				r.in1 = {c.fire_b, c.fire_a, c.one_player, c.two_players,
					c.up, c.left, c.right, c.down};
				r.in2[0] = c.fire_c;
			end
			7'd2: begin
				r.mayday = 1'b1;
				r.in0[0] = s[7];
				r.in0[1] = adv;
				r.in0[2] = hsr;
				r.in0[4] = c.coin1;
				r.in0[5] = c.coin2;
				r.in1 = {c.down, 1'b0, c.one_player, c.two_players,
					c.fire_b, c.fire_c, c.right, c.fire_a};
				r.in2[0] = c.up;
			end
			7'd3: begin
				r.orient = 2'b11;
				r.in0[3] = c.coin1;
				r.in0[4] = c.coin2;
				r.in1 = {c.fire_b, c.fire_a, c.one_player, c.two_players,
					c.right, c.left, c.down, c.up};
				r.in2[3] = s[10];
				r.in2[5] = ~s[11];
				r.in2[6] = ~s[12];
			end
			default: r.orient = 2'b10;
		endcase
		return r;
	endfunction

	// word expected at byte address a of a region
	function automatic defender_pkg::mem_word_t exp_word(input int base, input int a);
		defender_pkg::mem_word_t w;
		w.addr = defender_pkg::word_addr_t'((a - base) >> 1);
		if (a + 1 <= dl_last) begin
			w.data = {img(a + 1), img(a)};
			w.be   = 2'b11;
		end else begin
			w.data = {8'h00, img(a)};
			w.be   = 2'b01; // lone tail byte
		end
		return w;
	endfunction

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			main_n   <= 0;
			snd_n    <= 0;
			main_out <= 0;
			snd_out  <= 0;
			src_cr   <= defender_pkg::DL_CREDITS;
			adv_left <= 0;
			hsr_left <= 0;
			adv_prev <= 1'b0;
			hsr_prev <= 1'b0;
			exp_cr   <= 1'b1;
			err_map  <= 0;
			err_wr   <= 0;
			err_flow <= 0;
			err_load <= 0;
		end else begin
			// port mapping with the expected pulse levels
			exp_map = map_ref(core_mod, status, controls, adv_left > 0, hsr_left > 0);
			act_map = {input0, input1, input2, mayday, orientation};
			if (act_map !== exp_map) begin
				$display("Mismatch in %s: expected %h, actual %h",
					test_name(test_id), exp_map, act_map);
				err_map <= err_map + 1;
			end
			if (status[8] && !adv_prev)
				adv_left <= defender_pkg::PULSE_CYCLES;
			else if (adv_left > 0)
				adv_left <= adv_left - 1;
			if (status[9] && !hsr_prev)
				hsr_left <= defender_pkg::PULSE_CYCLES;
			else if (hsr_left > 0)
				hsr_left <= hsr_left - 1;
			adv_prev <= status[8];
			hsr_prev <= status[9];

			if (main_wr) begin
				if (main_n >= main_exp) begin
					$display("main port wrote more words than the download holds");
					err_wr <= err_wr + 1;
				end else if (main_word !== exp_word(defender_pkg::MAIN_BASE, dl_first + 2 * main_n)) begin
					$display("Mismatch in %s main word %0d: expected %h, actual %h",
						test_name(test_id), main_n,
						exp_word(defender_pkg::MAIN_BASE, dl_first + 2 * main_n), main_word);
					err_wr <= err_wr + 1;
				end
				main_n <= main_n + 1;
			end
			if (snd_wr) begin
				if (snd_n >= snd_exp) begin
					$display("sound port wrote more words than the download holds");
					err_wr <= err_wr + 1;
				end else if (snd_word !== exp_word(defender_pkg::SND_BASE,
					defender_pkg::SND_BASE + 2 * snd_n)) begin
					$display("Mismatch in %s sound word %0d: expected %h, actual %h",
						test_name(test_id), snd_n,
						exp_word(defender_pkg::SND_BASE, defender_pkg::SND_BASE + 2 * snd_n),
						snd_word);
					err_wr <= err_wr + 1;
				end
				snd_n <= snd_n + 1;
			end

			// credit bookkeeping on both sides
			main_out <= main_out + int'(main_wr) - int'(main_credit);
			snd_out  <= snd_out + int'(snd_wr) - int'(snd_credit);
			src_cr   <= src_cr + int'(dl_credit) - int'(dl_valid);
			if (main_out + int'(main_wr) > defender_pkg::MEM_CREDITS
				|| snd_out + int'(snd_wr) > defender_pkg::MEM_CREDITS) begin
				$display("a memory port has more writes outstanding than its credits");
				err_flow <= err_flow + 1;
			end
			if (src_cr + int'(dl_credit) - int'(dl_valid) > defender_pkg::DL_CREDITS) begin
				$display("download source was given more credits than it may hold");
				err_flow <= err_flow + 1;
			end

			// load status and core reset
			if (core_reset !== exp_cr) begin
				$display("Mismatch in %s core_reset: expected %b, actual %b",
					test_name(test_id), exp_cr, core_reset);
				err_load <= err_load + 1;
			end
			exp_cr <= status[0] | dl_download | !rom_loaded;
			if (led !== !dl_download) begin
				$display("Mismatch in %s led: expected %b, actual %b",
					test_name(test_id), !dl_download, led);
				err_load <= err_load + 1;
			end
			if (rom_loaded && (dl_download || main_out != 0 || snd_out != 0)) begin
				$display("rom_loaded is high before the download drained");
				err_load <= err_load + 1;
			end

			if (end_chk) begin
				if (main_n != main_exp || snd_n != snd_exp) begin
					$display("Mismatch in %s word counts: expected %0d/%0d, actual %0d/%0d",
						test_name(test_id), main_exp, snd_exp, main_n, snd_n);
					err_wr <= err_wr + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/glue_tb.sv
/* testbench for the defender glue: clock, reset, stimulus,
   download source, memory credit models and timeout */
`default_nettype none

module glue_tb;

	localparam int DL_FIRST   = 'h7300;
	localparam int DL_LAST    = 'h7500; // odd byte count, tail lands in sound
	localparam int DROP_BYTES = 3;
	localparam int DL_BYTES   = DL_LAST - DL_FIRST + 1 + DROP_BYTES;
	localparam int MAP_CYCLES = 6 * 8;
	localparam int PULSE_TEST = 2 * (defender_pkg::PULSE_CYCLES + 12);
	localparam int LIMIT      = 4 * DL_BYTES + MAP_CYCLES + PULSE_TEST + 500;

	logic                     clk_sys, arst_n;
	defender_pkg::core_mod_t  core_mod;
	defender_pkg::status_t    status;
	defender_pkg::controls_t  controls;
	logic                     dl_download, dl_valid;
	defender_pkg::dl_byte_t   dl;
	logic                     main_credit, snd_credit;
	logic                     dl_credit, main_wr, snd_wr;
	defender_pkg::mem_word_t  main_word, snd_word;
	defender_pkg::port_byte_t input0, input1, input2;
	logic                     mayday;
	logic [1:0]               orientation;
	logic                     rom_loaded, core_reset, led;
	logic [3:0]               test_id;
	logic                     end_chk;
	int                       err_map, err_wr, err_flow, err_load;
	int                       cycles, src_credits;
	integer                   seed;
	int                       main_q[$], snd_q[$];

	defender_glue_top DUT (.*);

	glue_checker #(.dl_first(DL_FIRST), .dl_last(DL_LAST)) u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	// memory ports hand back one credit per write after 0 to 3 cycles
	always @(posedge clk_sys) begin
		logic m_wr, s_wr;
		m_wr = main_wr;
		s_wr = snd_wr;
		#1;
		if (m_wr)
			main_q.push_back($random(seed) & 3);
		if (s_wr)
			snd_q.push_back($random(seed) & 3);
		main_credit = 1'b0;
		snd_credit  = 1'b0;
		if (main_q.size() > 0) begin
			if (main_q[0] == 0) begin
				void'(main_q.pop_front());
				main_credit = 1'b1;
			end else
				main_q[0] = main_q[0] - 1;
		end
		if (snd_q.size() > 0) begin
			if (snd_q[0] == 0) begin
				void'(snd_q.pop_front());
				snd_credit = 1'b1;
			end else
				snd_q[0] = snd_q[0] - 1;
		end
	end

	// one clock, with the download credit picked up at the edge
	task automatic step();
		@(posedge clk_sys);
		if (dl_credit)
			src_credits = src_credits + 1;
		#1;
	endtask

	task automatic send_byte(input logic [7:0] idx, input int a);
		while (src_credits == 0)
			step();
		dl_valid = 1'b1;
		dl = '{index: idx, addr: defender_pkg::byte_addr_t'(a), data: a[7:0] ^ 8'h5A};
		src_credits = src_credits - 1;
		step();
		dl_valid = 1'b0;
	endtask

	task automatic pulse_option(input int bit_no);
		repeat (3) step();
		status[bit_no] = 1'b1;
		repeat (5) step();
		status[bit_no] = 1'b0;
		repeat (defender_pkg::PULSE_CYCLES + 4) step();
	endtask

	initial begin
		int codes[6];
		int total;
		logic [31:0] rnd;
		codes = '{0, 1, 2, 3, 5, 100};
		seed = 80;
		cycles = 0;
		src_credits = defender_pkg::DL_CREDITS;
		arst_n = 1'b0;
		core_mod = '0;
		status = '0;
		controls = '0;
		dl_download = 1'b0;
		dl_valid = 1'b0;
		dl = '0;
		main_credit = 1'b0;
		snd_credit = 1'b0;
		test_id = 4'd0;
		end_chk = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1 arst_n = 1'b1;
		step();

		test_id = 4'd1;
		foreach (codes[i]) begin
			repeat (8) begin
				core_mod = defender_pkg::core_mod_t'(codes[i]);
				rnd = $random(seed);
				controls = rnd[11:0];
				status = $random(seed) & 32'hffff_fffe;
				step();
			end
		end

		test_id = 4'd2;
		core_mod = 7'd0;
		status = '0;
		pulse_option(8);
		pulse_option(9);

		test_id = 4'd3;
		dl_download = 1'b1;
		step();
		for (int a = 0; a < DROP_BYTES; a++)
			send_byte(8'h01, 'h100 + a); // not rom data
		for (int a = DL_FIRST; a <= DL_LAST; a++)
			send_byte(8'h00, a);
		while (src_credits < defender_pkg::DL_CREDITS)
			step();
		dl_download = 1'b0;
		while (!rom_loaded)
			step();
		while (core_reset)
			step();
		repeat (2) step();
		status[0] = 1'b1; // host reset request
		repeat (3) step();
		status[0] = 1'b0;
		repeat (3) step();
		end_chk = 1'b1;
		step();
		end_chk = 1'b0;
		step();

		total = err_map + err_wr + err_flow + err_load;
		$display("errors: mapping %0d, writes %0d, flow %0d, load %0d",
			err_map, err_wr, err_flow, err_load);
		if (total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- common/defender_pkg.sv
/* shared widths, port structs and game variant codes
   ROM map of the two regions, credit counts and pulse length */
`default_nettype none

package defender_pkg;

	localparam int BYTE_ADDR_W = 25;
	localparam int WORD_ADDR_W = 15;

	typedef logic [7:0]             port_byte_t; // one core input port
	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t; // word offset inside a region
	typedef logic [6:0]             core_mod_t;
	typedef logic [31:0]            status_t;

	// option word bits
	localparam int STAT_RESET   = 0;
	localparam int STAT_AUTOUP  = 7;
	localparam int STAT_ADVANCE = 8;
	localparam int STAT_HSRESET = 9;
	localparam int STAT_DIP     = 10; // three dip bits from here up

	typedef enum core_mod_t {
		DEFENDER = 7'd0,
		COLONY7  = 7'd1,
		MAYDAY   = 7'd2,
		JIN      = 7'd3
	} game_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic one_player;
		logic two_players;
		logic coin1;
		logic coin2;
	} controls_t;

	typedef struct packed {
		logic [7:0] index;
		byte_addr_t addr;
		logic [7:0] data;
	} dl_byte_t;

	typedef struct packed {
		word_addr_t  addr;
		logic [15:0] data;
		logic [1:0]  be; // bit 0 low byte, bit 1 high byte
	} mem_word_t;

	// main cpu and decoder 0000-73ff, sound cpu 7400-7bff
	localparam int MAIN_BASE  = 'h0000;
	localparam int MAIN_WORDS = 'h3A00;
	localparam int SND_BASE   = 'h7400;
	localparam int SND_WORDS  = 'h0400;
	localparam int ROM_END    = SND_BASE + 2 * SND_WORDS;

	localparam int MEM_CREDITS  = 2;
	localparam int DL_CREDITS   = 1;
	localparam int MEM_CREDIT_W = $clog2(MEM_CREDITS + 1);

	typedef logic [MEM_CREDIT_W-1:0] credit_t;

	localparam int PULSE_CYCLES = 32; // short enough to watch in simulation

endpackage

`default_nettype wire

//--- rom_loader/load_control.sv
/* download index filter, byte credit return and
   load status FSM driving rom_loaded and the core reset */
`default_nettype none

module load_control (
	input  wire logic                   clk_sys,
	input  wire logic                   arst_n,
	input  wire logic                   dl_download,
	input  wire logic                   dl_valid,
	input  wire defender_pkg::dl_byte_t dl,
	input  wire defender_pkg::status_t  status,
	input  wire logic                   main_free,
	input  wire logic                   snd_free,
	input  wire logic                   main_done,
	input  wire logic                   snd_done,
	output logic                        wr_valid,
	output logic                        dl_credit,
	output logic                        rom_loaded,
	output logic                        core_reset,
	output logic                        led
);

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_BUSY,  // download running
		LD_DRAIN, // waiting on both writers
		LD_DONE
	} load_state_t;

	load_state_t state;
	logic        drop_free;

	// only index 0 carries rom data
	assign wr_valid = dl_valid && dl.index == 8'h00;

	// free pulses never overlap with one byte in flight
	assign dl_credit  = main_free || snd_free || drop_free;
	assign rom_loaded = (state == LD_DONE);
	assign led        = ~dl_download;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= LD_IDLE;
			drop_free  <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			drop_free  <= dl_valid && dl.index != 8'h00;
			core_reset <= status[defender_pkg::STAT_RESET] || dl_download || !rom_loaded;
			case (state)
				LD_IDLE: begin
					if (dl_download)
						state <= LD_BUSY;
				end
				LD_BUSY: begin
					if (!dl_download)
						state <= LD_DRAIN;
				end
				LD_DRAIN: begin
					if (dl_download)
						state <= LD_BUSY; // restarted before the drain finished
					else if (main_done && snd_done)
						state <= LD_DONE;
				end
				LD_DONE: begin
					if (dl_download)
						state <= LD_BUSY;
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rom_loader/rom_region_writer.sv
/* packs download bytes of one address region into 16-bit words,
   queues them in a two-entry buffer and issues them against memory credits */
`default_nettype none

module rom_region_writer #(
	parameter int unsigned region_base  = 0,
	parameter int unsigned region_words = 1
) (
	input  wire logic                   clk_sys,
	input  wire logic                   arst_n,
	input  wire logic                   dl_download,
	input  wire logic                   dl_valid,
	input  wire defender_pkg::dl_byte_t dl,
	input  wire logic                   credit,
	output logic                        byte_free,
	output logic                        wr,
	output defender_pkg::mem_word_t     word,
	output logic                        done
);

	localparam int aw = defender_pkg::BYTE_ADDR_W;
	localparam defender_pkg::byte_addr_t base_addr = defender_pkg::byte_addr_t'(region_base);
	localparam defender_pkg::byte_addr_t span = defender_pkg::byte_addr_t'(2 * region_words);
	// the region at the top of the map also takes the tail past it
	localparam bit last_region = (region_base + 2 * region_words) == defender_pkg::ROM_END;

	defender_pkg::dl_byte_t   slot, cur;
	logic                     slot_valid, cur_valid;
	logic [7:0]               lo_data;
	defender_pkg::word_addr_t lo_addr, cur_waddr;
	logic                     lo_valid;
	defender_pkg::mem_word_t  fifo [2];
	logic                     rd_ptr, wr_ptr;
	logic [1:0]               count;
	defender_pkg::credit_t    credits;
	logic [aw:0]              off_in, off_cur; // top bit is the borrow
	logic                     claim, in_range;
	logic                     pop, room, push, move, lo_load;
	defender_pkg::mem_word_t  push_word;

	assign off_in    = {1'b0, dl.addr} - {1'b0, base_addr};
	assign claim     = dl_valid && !off_in[aw] && (last_region || off_in[aw-1:0] < span);
	assign cur_valid = slot_valid || claim;
	assign cur       = slot_valid ? slot : dl;
	assign off_cur   = {1'b0, cur.addr} - {1'b0, base_addr};
	assign in_range  = off_cur[aw-1:0] < span;
	assign cur_waddr = off_cur[defender_pkg::WORD_ADDR_W:1];

	always_comb begin
		pop       = (count != 2'd0) && (credits != '0);
		room      = (count != 2'd2) || pop;
		push      = 1'b0;
		move      = 1'b0;
		lo_load   = 1'b0;
		push_word = '{addr: lo_addr, data: {8'h00, lo_data}, be: 2'b01}; // lone low byte
		if (cur_valid) begin
			if (!in_range) begin
				move = 1'b1; // dropped, slot still freed
			end else if (lo_valid && cur.addr[0] && lo_addr == cur_waddr) begin
				push           = room;
				move           = room;
				push_word.data = {cur.data, lo_data};
				push_word.be   = 2'b11;
			end else if (lo_valid) begin
				push = room; // gap in the stream, flush the low half first
			end else if (!cur.addr[0]) begin
				move    = 1'b1;
				lo_load = 1'b1;
			end else begin
				push      = room;
				move      = room;
				push_word = '{addr: cur_waddr, data: {cur.data, 8'h00}, be: 2'b10};
			end
		end else if (!dl_download && lo_valid) begin
			push = room; // end of download
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= 1'b0;
			lo_valid   <= 1'b0;
			byte_free  <= 1'b0;
			wr         <= 1'b0;
			rd_ptr     <= 1'b0;
			wr_ptr     <= 1'b0;
			count      <= 2'd0;
			credits    <= defender_pkg::credit_t'(defender_pkg::MEM_CREDITS);
		end else begin
			slot_valid <= cur_valid && !move;
			lo_valid   <= lo_load || (lo_valid && !push);
			byte_free  <= move;
			wr         <= pop;
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			count   <= count + {1'b0, push} - {1'b0, pop};
			credits <= credits + defender_pkg::credit_t'(credit)
				- defender_pkg::credit_t'(pop);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cur_valid)
			slot <= cur;
		if (lo_load) begin
			lo_data <= cur.data;
			lo_addr <= cur_waddr;
		end
		if (push)
			fifo[wr_ptr] <= push_word;
		if (pop)
			word <= fifo[rd_ptr];
	end

	assign done = !dl_download && !slot_valid && !lo_valid && count == 2'd0
		&& credits == defender_pkg::credit_t'(defender_pkg::MEM_CREDITS);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the glue testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module glue_tb -f verilog.f -o glue_sim \
	&& ./obj_dir/glue_sim > sim.log 2>&1 \
	|| echo "build or run error" >> sim.log

cat sim.log
grep -qx "Test passed" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verilog.f
common/defender_pkg.sv
verilog/button_pulse.sv
verilog/input_mapper.sv
rom_loader/rom_region_writer.sv
rom_loader/load_control.sv
verilog/defender_glue_top.sv
bench/glue_checker.sv
bench/glue_tb.sv

//--- verilog/button_pulse.sv
/* rising-edge detector that stretches a button press
   into a fixed-length pulse */
`default_nettype none

module button_pulse #(
	parameter int unsigned pulse_cycles = 32
) (
	input  wire logic clk_sys,
	input  wire logic arst_n,
	input  wire logic btn,
	output logic      pulse
);

	localparam int unsigned cnt_w = $clog2(pulse_cycles + 1);

	logic             btn_d;
	logic [cnt_w-1:0] count;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn_d <= 1'b0;
			count <= '0;
		end else begin
			btn_d <= btn;
			if (btn && !btn_d)
				count <= cnt_w'(pulse_cycles); // new press restarts the pulse
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	assign pulse = (count != '0);

endmodule

`default_nettype wire

//--- verilog/defender_glue_top.sv
/* glue between the host loader and the defender core:
   input mapping, option pulses and the two rom region writers */
`default_nettype none

module defender_glue_top (
	input  wire logic                    clk_sys,
	input  wire logic                    arst_n,
	input  wire defender_pkg::core_mod_t core_mod,
	input  wire defender_pkg::status_t   status,
	input  wire defender_pkg::controls_t controls,
	input  wire logic                    dl_download,
	input  wire logic                    dl_valid,
	input  wire defender_pkg::dl_byte_t  dl,
	input  wire logic                    main_credit,
	input  wire logic                    snd_credit,
	output wire logic                    dl_credit,
	output wire logic                    main_wr,
	output wire defender_pkg::mem_word_t main_word,
	output wire logic                    snd_wr,
	output wire defender_pkg::mem_word_t snd_word,
	output wire defender_pkg::port_byte_t input0,
	output wire defender_pkg::port_byte_t input1,
	output wire defender_pkg::port_byte_t input2,
	output wire logic                    mayday,
	output wire logic [1:0]              orientation,
	output wire logic                    rom_loaded,
	output wire logic                    core_reset,
	output wire logic                    led
);

	wire logic advance, hs_reset;
	wire logic wr_valid;
	wire logic main_free, snd_free;
	wire logic main_done, snd_done;

	button_pulse #(.pulse_cycles(defender_pkg::PULSE_CYCLES)) u_adv_pulse (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.btn     (status[defender_pkg::STAT_ADVANCE]),
		.pulse   (advance)
	);

	button_pulse #(.pulse_cycles(defender_pkg::PULSE_CYCLES)) u_hsr_pulse (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.btn     (status[defender_pkg::STAT_HSRESET]),
		.pulse   (hs_reset)
	);

	input_mapper u_input_mapper (
		.core_mod    (core_mod),
		.status      (status),
		.controls    (controls),
		.advance     (advance),
		.hs_reset    (hs_reset),
		.input0      (input0),
		.input1      (input1),
		.input2      (input2),
		.mayday      (mayday),
		.orientation (orientation)
	);

	load_control u_load_control (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_download (dl_download),
		.dl_valid    (dl_valid),
		.dl          (dl),
		.status      (status),
		.main_free   (main_free),
		.snd_free    (snd_free),
		.main_done   (main_done),
		.snd_done    (snd_done),
		.wr_valid    (wr_valid),
		.dl_credit   (dl_credit),
		.rom_loaded  (rom_loaded),
		.core_reset  (core_reset),
		.led         (led)
	);

	// main cpu program and decoder
	rom_region_writer #(
		.region_base  (defender_pkg::MAIN_BASE),
		.region_words (defender_pkg::MAIN_WORDS)
	) u_main_writer (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_download (dl_download),
		.dl_valid    (wr_valid),
		.dl          (dl),
		.credit      (main_credit),
		.byte_free   (main_free),
		.wr          (main_wr),
		.word        (main_word),
		.done        (main_done)
	);

	rom_region_writer #(
		.region_base  (defender_pkg::SND_BASE),
		.region_words (defender_pkg::SND_WORDS)
	) u_snd_writer (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_download (dl_download),
		.dl_valid    (wr_valid),
		.dl          (dl),
		.credit      (snd_credit),
		.byte_free   (snd_free),
		.wr          (snd_wr),
		.word        (snd_word),
		.done        (snd_done)
	);

endmodule

`default_nettype wire

//--- verilog/input_mapper.sv
/* maps player controls and option bits onto the three
   core input ports, the mayday flag and the screen orientation */
`default_nettype none

module input_mapper (
	input  wire defender_pkg::core_mod_t core_mod,
	input  wire defender_pkg::status_t   status,
	input  wire defender_pkg::controls_t controls,
	input  wire logic                    advance,
	input  wire logic                    hs_reset,
	output defender_pkg::port_byte_t     input0,
	output defender_pkg::port_byte_t     input1,
	output defender_pkg::port_byte_t     input2,
	output logic                         mayday,
	output logic [1:0]                   orientation
);

	defender_pkg::game_t game;
	logic                autoup;
	logic [2:0]          dip;

	assign game   = defender_pkg::game_t'(core_mod);
	assign autoup = status[defender_pkg::STAT_AUTOUP];
	assign dip    = status[defender_pkg::STAT_DIP +: 3];

	always_comb begin
		mayday      = 1'b0;
		input0      = '0;
		input1      = '0;
		input2      = '0;
		orientation = 2'b10; // landscape

		case (game)
			defender_pkg::DEFENDER: begin
				// rom board pia port a
				input0 = {3'b000, controls.coin1, hs_reset, 1'b0, advance, autoup};
				// thrust is either stick direction, reverse is taken from down
				input1 = {controls.down, controls.left | controls.right,
					controls.one_player, controls.two_players,
					controls.fire_d, controls.fire_c, controls.fire_b, controls.fire_a};
				input2 = {7'b0000000, controls.up};
			end
			defender_pkg::COLONY7: begin
				orientation = 2'b01;
				input0 = {3'b000, controls.coin1, 2'b00, dip[1], dip[0]}; // bonus, lives
				input1 = {controls.fire_b, controls.fire_a,
					controls.one_player, controls.two_players,
					controls.up, controls.left, controls.right, controls.down};
				input2 = {7'b0000000, controls.fire_c};
			end
			defender_pkg::MAYDAY: begin
				mayday = 1'b1; // protection check on
				input0 = {2'b00, controls.coin2, controls.coin1, 1'b0,
					hs_reset, advance, autoup};
				input1 = {controls.down, 1'b0,
					controls.one_player, controls.two_players,
					controls.fire_b, controls.fire_c, controls.right, controls.fire_a};
				input2 = {7'b0000000, controls.up};
			end
			defender_pkg::JIN: begin
				orientation = 2'b11;
				input0 = {3'b000, controls.coin2, controls.coin1, 3'b000};
				input1 = {controls.fire_b, controls.fire_a,
					controls.one_player, controls.two_players,
					controls.right, controls.left, controls.down, controls.up};
				// level dips are active low, lives in bit 3
				input2 = {1'b0, ~dip[2:1], 1'b0, dip[0], 3'b000};
			end
			default: begin
				input0 = '0; // unknown variant, ports stay quiet
			end
		endcase
	end

endmodule

`default_nettype wire
